// File: cpu_bus_cfg.svh
`ifndef CPU_BUS_CFG_SVH
`define CPU_BUS_CFG_SVH

// Request FIFO depth and initial requester credits
`define CPU_BUS_REQ_DEPTH 4

// Pending read slots per bank
`define CPU_BUS_BANK_CREDITS 2

`define CPU_BUS_ORDER_DEPTH 8
`define CPU_BUS_NUM_BANKS 3

// Bank address widths
`define CPU_BUS_RAM_AW 11
`define CPU_BUS_REG_AW 3
`define CPU_BUS_CART_AW 13

// Region bases on 8 KB boundaries
`define CPU_BUS_REGION_AW 13
`define CPU_BUS_RAM_BASE 16'h0000
`define CPU_BUS_REG_BASE 16'h2000
`define CPU_BUS_CART_BASE 16'h6000

`endif

// File: cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    // CPU byte address
    typedef logic [15:0] cpu_addr_t;

    // One data byte
    typedef logic [7:0] cpu_data_t;

    // Bank index with 3 for unmapped
    typedef logic [1:0] bank_sel_t;

    // Offset after mirroring, sized for the cartridge bank
    typedef logic [12:0] bank_off_t;

    ////////////////////
    // Bank select codes
    ////////////////////

    localparam bank_sel_t SEL_RAM  = 2'd0;
    localparam bank_sel_t SEL_REG  = 2'd1;
    localparam bank_sel_t SEL_CART = 2'd2;
    localparam bank_sel_t SEL_OPEN = 2'd3;

endpackage

`default_nettype wire

// File: cpu_bus_if.sv
`default_nettype none

////////////////////
// Request channel
////////////////////

interface bank_req_if;
    import cpu_bus_pkg::*;

    logic      valid;
    logic      rw;
    bank_off_t off;
    cpu_data_t wdata;
    // One pulse per freed slot or finished write
    logic      credit;

    modport dispatch (
        output valid,
        output rw,
        output off,
        output wdata,
        input  credit
    );

    modport bank (
        input  valid,
        input  rw,
        input  off,
        input  wdata,
        output credit
    );
endinterface

////////////////////
// Response channel
////////////////////

interface bank_rsp_if;
    import cpu_bus_pkg::*;

    // High while the bank's output slot holds data
    logic      valid;
    cpu_data_t data;
    logic      pop;

    modport bank (
        output valid,
        output data,
        input  pop
    );

    modport collect (
        input  valid,
        input  data,
        output pop
    );
endinterface

`default_nettype wire

// File: cpu_bus_dispatch.sv
`default_nettype none
`include "cpu_bus_cfg.svh"

module cpu_bus_dispatch (
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    input  wire                         i_req_valid,
    input  wire                         i_req_rw,
    input  wire cpu_bus_pkg::cpu_addr_t i_req_addr,
    input  wire cpu_bus_pkg::cpu_data_t i_req_wdata,
    output logic                        o_req_credit,
    bank_req_if.dispatch                o_bank [`CPU_BUS_NUM_BANKS],
    output logic                        o_ord_push,
    output cpu_bus_pkg::bank_sel_t      o_ord_sel,
    input  wire                         i_ord_full
);
    import cpu_bus_pkg::*;

    localparam int DEPTH = `CPU_BUS_REQ_DEPTH;
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam int BCW = $clog2(`CPU_BUS_BANK_CREDITS + 1);
    localparam int NSEL = 2 ** $bits(bank_sel_t);
    localparam int RAW = `CPU_BUS_REGION_AW;
    localparam cpu_addr_t RAM_BASE = `CPU_BUS_RAM_BASE;
    localparam cpu_addr_t REG_BASE = `CPU_BUS_REG_BASE;
    localparam cpu_addr_t CART_BASE = `CPU_BUS_CART_BASE;

    logic          fifo_rw [DEPTH];
    cpu_addr_t     fifo_addr [DEPTH];
    cpu_data_t     fifo_wdata [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] fifo_cnt;

    logic            head_rw;
    cpu_addr_t       head_addr;
    bank_sel_t       head_sel;
    bank_off_t       head_off;
    logic [NSEL-1:0] bank_ok;
    logic            fifo_pop;
    logic            send;

    logic      send_rw_q;
    bank_off_t send_off_q;
    cpu_data_t send_data_q;

    ////////////////////
    // Request FIFO
    ////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
            o_req_credit <= 1'b0;
        end else begin
            if (i_req_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo_pop)
                rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt <= fifo_cnt + CW'(i_req_valid) - CW'(fifo_pop);
            // Every entry that leaves hands a credit back
            o_req_credit <= fifo_pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            fifo_rw[wr_ptr] <= i_req_rw;
            fifo_addr[wr_ptr] <= i_req_addr;
            fifo_wdata[wr_ptr] <= i_req_wdata;
        end
    end

    assign head_rw = fifo_rw[rd_ptr];
    assign head_addr = fifo_addr[rd_ptr];

    ////////////////////
    // Address decode
    ////////////////////

    always_comb begin
        head_sel = SEL_OPEN;
        head_off = '0;
        // Mirroring falls out of dropping the upper offset bits
        if (head_addr[15:RAW] == RAM_BASE[15:RAW]) begin
            head_sel = SEL_RAM;
            head_off = bank_off_t'(head_addr[`CPU_BUS_RAM_AW-1:0]);
        end else if (head_addr[15:RAW] == REG_BASE[15:RAW]) begin
            head_sel = SEL_REG;
            head_off = bank_off_t'(head_addr[`CPU_BUS_REG_AW-1:0]);
        end else if (head_addr[15:RAW] == CART_BASE[15:RAW]) begin
            head_sel = SEL_CART;
            head_off = bank_off_t'(head_addr[`CPU_BUS_CART_AW-1:0]);
        end
    end

    // Unmapped writes leave the FIFO here and go nowhere
    assign fifo_pop = (fifo_cnt != '0) && bank_ok[head_sel] && !(head_rw && i_ord_full);
    assign send = fifo_pop && (head_sel != SEL_OPEN);
    assign o_ord_push = fifo_pop && head_rw;
    assign o_ord_sel = head_sel;

    always_ff @(posedge i_clk) begin
        if (send) begin
            send_rw_q <= head_rw;
            send_off_q <= head_off;
            send_data_q <= fifo_wdata[rd_ptr];
        end
    end

    ////////////////////
    // Bank credits
    ////////////////////

    for (genvar g = 0; g < NSEL; g++) begin : g_sel
        if (g < `CPU_BUS_NUM_BANKS) begin : g_bank
            logic [BCW-1:0] credits;
            logic           valid_q;
            logic           take;

            assign take = send && (head_sel == bank_sel_t'(g));

            always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                    credits <= BCW'(`CPU_BUS_BANK_CREDITS);
                    valid_q <= 1'b0;
                end else begin
                    credits <= credits + BCW'(o_bank[g].credit) - BCW'(take);
                    valid_q <= take;
                end
            end

            assign bank_ok[g] = (credits != '0);
            assign o_bank[g].valid = valid_q;
            assign o_bank[g].rw = send_rw_q;
            assign o_bank[g].off = send_off_q;
            assign o_bank[g].wdata = send_data_q;
        end else begin : g_open
            // Open bus needs no bank credit
            assign bank_ok[g] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: cpu_bus_bank.sv
`default_nettype none
`include "cpu_bus_cfg.svh"

module cpu_bus_bank #(
    parameter int BANK_AW = 11
) (
    input  wire      i_clk,
    input  wire      i_arst_n,
    bank_req_if.bank i_req,
    bank_rsp_if.bank o_rsp
);
    import cpu_bus_pkg::*;

    localparam int SLOTS = `CPU_BUS_BANK_CREDITS;
    localparam int SPW = $clog2(SLOTS);
    localparam int SCW = $clog2(SLOTS + 1);

    cpu_data_t mem [2 ** BANK_AW];
    cpu_data_t slot [SLOTS];

    logic [BANK_AW-1:0] addr;
    logic               wr_req;
    logic               rd_req;
    logic [SPW-1:0]     slot_wr;
    logic [SPW-1:0]     slot_rd;
    logic [SCW-1:0]     slot_cnt;
    logic [SCW-1:0]     owed;
    logic [SCW-1:0]     owed_sum;
    logic               credit_q;

    assign addr = i_req.off[BANK_AW-1:0];
    assign wr_req = i_req.valid && !i_req.rw;
    assign rd_req = i_req.valid && i_req.rw;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (wr_req)
            mem[addr] <= i_req.wdata;
        // Read lands in the output slot a cycle later
        if (rd_req)
            slot[slot_wr] <= mem[addr];
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            slot_wr <= '0;
            slot_rd <= '0;
            slot_cnt <= '0;
        end else begin
            if (rd_req)
                slot_wr <= slot_wr + 1'b1;
            if (o_rsp.pop)
                slot_rd <= slot_rd + 1'b1;
            slot_cnt <= slot_cnt + SCW'(rd_req) - SCW'(o_rsp.pop);
        end
    end

    assign o_rsp.valid = (slot_cnt != '0);
    assign o_rsp.data = slot[slot_rd];

    ////////////////////
    // Credit return
    ////////////////////

    // A write and a pop in one cycle owe two credits, one waits
    assign owed_sum = owed + SCW'(wr_req) + SCW'(o_rsp.pop);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            owed <= '0;
            credit_q <= 1'b0;
        end else begin
            credit_q <= (owed_sum != '0);
            owed <= owed_sum - SCW'(owed_sum != '0);
        end
    end

    assign i_req.credit = credit_q;

endmodule

`default_nettype wire

// File: cpu_bus_collect.sv
`default_nettype none
`include "cpu_bus_cfg.svh"

module cpu_bus_collect (
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    input  wire                         i_ord_push,
    input  wire cpu_bus_pkg::bank_sel_t i_ord_sel,
    output logic                        o_ord_full,
    bank_rsp_if.collect                 i_bank [`CPU_BUS_NUM_BANKS],
    input  wire                         i_rsp_credit,
    output logic                        o_rsp_valid,
    output cpu_bus_pkg::cpu_data_t      o_rsp_data
);
    import cpu_bus_pkg::*;

    localparam int DEPTH = `CPU_BUS_ORDER_DEPTH;
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam int NSEL = 2 ** $bits(bank_sel_t);
    localparam int RCW = 8;

    bank_sel_t     ord_q [DEPTH];
    logic [PW-1:0] ord_wr;
    logic [PW-1:0] ord_rd;
    logic [CW-1:0] ord_cnt;
    bank_sel_t     head;

    logic [RCW-1:0]  rsp_credits;
    logic [NSEL-1:0] src_vld;
    cpu_data_t       src_data [NSEL];
    cpu_data_t       open_bus_q;
    logic            fire;

    ////////////////////
    // Order queue
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_ord_push)
            ord_q[ord_wr] <= i_ord_sel;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ord_wr <= '0;
            ord_rd <= '0;
            ord_cnt <= '0;
        end else begin
            if (i_ord_push)
                ord_wr <= ord_wr + 1'b1;
            if (fire)
                ord_rd <= ord_rd + 1'b1;
            ord_cnt <= ord_cnt + CW'(i_ord_push) - CW'(fire);
        end
    end

    assign head = ord_q[ord_rd];
    assign o_ord_full = (ord_cnt == CW'(DEPTH));

    ////////////////////
    // Response merge
    ////////////////////

    for (genvar g = 0; g < NSEL; g++) begin : g_src
        if (g < `CPU_BUS_NUM_BANKS) begin : g_bank
            assign src_vld[g] = i_bank[g].valid;
            assign src_data[g] = i_bank[g].data;
            assign i_bank[g].pop = fire && (head == bank_sel_t'(g));
        end else begin : g_open
            // Open bus is always ready with the held byte
            assign src_vld[g] = 1'b1;
            assign src_data[g] = open_bus_q;
        end
    end

    assign fire = (ord_cnt != '0) && (rsp_credits != '0) && src_vld[head];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rsp_credits <= '0;
            o_rsp_valid <= 1'b0;
            open_bus_q <= '0;
        end else begin
            rsp_credits <= rsp_credits + RCW'(i_rsp_credit) - RCW'(fire);
            o_rsp_valid <= fire;
            // Each returned byte becomes the next open bus value
            if (fire)
                open_bus_q <= src_data[head];
        end
    end

    assign o_rsp_data = open_bus_q;

endmodule

`default_nettype wire

// File: cpu_bus_map.sv
`default_nettype none
`include "cpu_bus_cfg.svh"

module cpu_bus_map (
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    input  wire                         i_req_valid,
    input  wire                         i_req_rw,
    input  wire cpu_bus_pkg::cpu_addr_t i_req_addr,
    input  wire cpu_bus_pkg::cpu_data_t i_req_wdata,
    output logic                        o_req_credit,
    output logic                        o_rsp_valid,
    output cpu_bus_pkg::cpu_data_t      o_rsp_data,
    input  wire                         i_rsp_credit
);
    import cpu_bus_pkg::*;

    bank_req_if req_bus [`CPU_BUS_NUM_BANKS] ();
    bank_rsp_if rsp_bus [`CPU_BUS_NUM_BANKS] ();

    logic      ord_push;
    bank_sel_t ord_sel;
    logic      ord_full;

    cpu_bus_dispatch dispatch (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req_valid  (i_req_valid),
        .i_req_rw     (i_req_rw),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .o_req_credit (o_req_credit),
        .o_bank       (req_bus),
        .o_ord_push   (ord_push),
        .o_ord_sel    (ord_sel),
        .i_ord_full   (ord_full)
    );

    // Work RAM, register file and cartridge RAM by index
    for (genvar g = 0; g < `CPU_BUS_NUM_BANKS; g++) begin : g_bank
        localparam int AW = (g == 0) ? `CPU_BUS_RAM_AW :
                            (g == 1) ? `CPU_BUS_REG_AW : `CPU_BUS_CART_AW;

        cpu_bus_bank #(
            .BANK_AW (AW)
        ) bank (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_req    (req_bus[g]),
            .o_rsp    (rsp_bus[g])
        );
    end

    cpu_bus_collect collect (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_ord_push   (ord_push),
        .i_ord_sel    (ord_sel),
        .o_ord_full   (ord_full),
        .i_bank       (rsp_bus),
        .i_rsp_credit (i_rsp_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data)
    );

endmodule

`default_nettype wire

// File: cpu_bus_checker.sv
`default_nettype none

module cpu_bus_checker (
    input wire                         i_clk,
    input wire                         i_arst_n,
    input wire                         i_rsp_credit,
    input wire                         o_req_credit,
    input wire                         o_rsp_valid,
    input wire cpu_bus_pkg::cpu_data_t o_rsp_data
);
    timeunit 1ns;
    timeprecision 100ps;

    // Credits granted minus responses seen
    logic [15:0] avail;
    int          fail_count = 0;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            avail <= '0;
        else
            avail <= avail + 16'(i_rsp_credit) - 16'(o_rsp_valid);
    end

    a_rsp_has_credit: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_rsp_valid |-> (avail != '0))
    else begin
        $error("Response issued without a granted credit");
        fail_count++;
    end

    a_rsp_data_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_rsp_valid |-> !$isunknown(o_rsp_data))
    else begin
        $error("Response data has unknown bits");
        fail_count++;
    end

    a_quiet_in_reset: assert property (@(posedge i_clk)
        !i_arst_n |-> (!o_req_credit && !o_rsp_valid))
    else begin
        $error("Credit or response strobe high during reset");
        fail_count++;
    end

endmodule

bind cpu_bus_map cpu_bus_checker chk (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_rsp_credit (i_rsp_credit),
    .o_req_credit (o_req_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_data   (o_rsp_data)
);

`default_nettype wire

// File: cpu_bus_tb.sv
`default_nettype none
`include "cpu_bus_cfg.svh"

module cpu_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_bus_pkg::*;

    // RAM, then 8 registers, then cartridge RAM
    localparam int MODEL_SIZE = 2048 + 8 + 8192;
    localparam int STALL_CYCLES = 16;
    localparam int GRANT_EAGER = 0;
    localparam int GRANT_HOLD = 1;
    localparam int GRANT_SLOW = 2;
    localparam int GRANT_RANDOM = 3;

    typedef struct packed {
        logic       rw;
        cpu_addr_t  addr;
        cpu_data_t  data;
        logic [1:0] phase;
    } row_t;

    logic      i_clk;
    logic      i_arst_n;
    logic      i_req_valid;
    logic      i_req_rw;
    cpu_addr_t i_req_addr;
    cpu_data_t i_req_wdata;
    logic      o_req_credit;
    logic      o_rsp_valid;
    cpu_data_t o_rsp_data;
    logic      i_rsp_credit;

    row_t       tbl[$];
    cpu_data_t  exp_q[$];
    cpu_addr_t  exp_addr_q[$];
    cpu_data_t  mem_m [MODEL_SIZE];
    bit         seen [MODEL_SIZE];
    cpu_data_t  open_m = '0;
    integer     seed = 32'hab2b;
    logic [1:0] build_phase;
    logic [1:0] cur_phase = GRANT_EAGER;
    int         grant_mode = GRANT_EAGER;
    int         row_idx = 0;
    int         req_credits = `CPU_BUS_REQ_DEPTH;
    int         rsp_owed = 0;
    int         stall_cnt = 0;
    bit         stall_seen = 1'b0;
    int         data_errs = 0;
    int         proto_errs = 0;
    int         cycles = 0;
    int         cycle_limit = 0;

    cpu_bus_map dut (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req_valid  (i_req_valid),
        .i_req_rw     (i_req_rw),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .o_req_credit (o_req_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .i_rsp_credit (i_rsp_credit)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Flat model index after mirroring, -1 when unmapped
    function automatic int model_index(input cpu_addr_t a);
        if (a < 16'h2000)
            return int'(a) % 2048;
        if (a < 16'h4000)
            return 2048 + (int'(a) - 'h2000) % 8;
        if (a >= 16'h6000 && a < 16'h8000)
            return 2056 + int'(a) - 'h6000;
        return -1;
    endfunction

    task automatic apply_model(input row_t row);
        int        idx;
        cpu_data_t exp;
        idx = model_index(row.addr);
        if (row.rw) begin
            exp = (idx >= 0) ? mem_m[idx] : open_m;
            open_m = exp;
            exp_q.push_back(exp);
            exp_addr_q.push_back(row.addr);
        end else if (idx >= 0) begin
            mem_m[idx] = row.data;
        end
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic add_row(input logic rw, input cpu_addr_t addr, input cpu_data_t data,
                           input logic [1:0] phase);
        int idx;
        idx = model_index(addr);
        if (!rw && idx >= 0)
            seen[idx] = 1'b1;
        tbl.push_back('{rw, addr, data, phase});
    endtask

    task automatic add_write(input cpu_addr_t addr, input cpu_data_t data);
        add_row(1'b0, addr, data, build_phase);
    endtask

    task automatic add_read(input cpu_addr_t addr);
        add_row(1'b1, addr, 8'h00, build_phase);
    endtask

    task automatic add_random_row();
        int        kind;
        int        idx;
        logic      rw;
        cpu_addr_t addr;
        kind = $random(seed) & 3;
        // Small offset pools so reads often hit written bytes
        case (kind)
            0: addr = cpu_addr_t'(($random(seed) & 'h1800) | 'h0040 | ($random(seed) & 'hF));
            1: addr = cpu_addr_t'('h2000 | ($random(seed) & 'h1FFF));
            2: addr = cpu_addr_t'('h7F00 | ($random(seed) & 'hF));
            default: begin
                if (($random(seed) & 1) != 0)
                    addr = cpu_addr_t'('h4000 | ($random(seed) & 'h1FFF));
                else
                    addr = cpu_addr_t'('h8000 | ($random(seed) & 'h7FFF));
            end
        endcase
        rw = (($random(seed) & 1) != 0);
        idx = model_index(addr);
        // Unwritten storage holds unknown data, so write it instead
        if (rw && idx >= 0 && !seen[idx])
            rw = 1'b0;
        add_row(rw, addr, cpu_data_t'($random(seed)), GRANT_RANDOM);
    endtask

    task automatic build_table();
        cpu_addr_t bp_addr [14] = '{16'h0123, 16'h2003, 16'h6010, 16'h0010, 16'h2005,
                                    16'h7FFF, 16'h0923, 16'h3FFF, 16'h6000, 16'h1FFF,
                                    16'h2001, 16'h6FFF, 16'h4000, 16'h0123};
        build_phase = GRANT_EAGER;
        // Open bus is zero straight after reset
        add_read(16'h4020);
        add_write(16'h0123, 8'hA5);
        add_read(16'h0123);
        add_read(16'h0923);
        add_read(16'h1923);
        add_read(16'h5000);
        add_write(16'h2003, 8'h3C);
        add_read(16'h3FFB);
        for (int i = 0; i < 8; i++)
            add_write(cpu_addr_t'('h2000 + i * 9), cpu_data_t'('h90 + i));
        for (int i = 0; i < 8; i++)
            add_read(cpu_addr_t'('h3FF8 + i));
        add_read(16'h8000);
        add_write(16'h4020, 8'hEE);
        add_write(16'h8000, 8'hEE);
        add_read(16'h4020);
        add_write(16'h0010, 8'h55);
        add_write(16'h07FF, 8'h66);
        add_write(16'h6000, 8'h11);
        add_write(16'h6010, 8'h22);
        add_write(16'h6FFF, 8'h33);
        add_write(16'h7FFF, 8'h44);
        add_write(16'h67FF, 8'h77);
        add_read(16'h6000);
        add_read(16'h6010);
        add_read(16'h6FFF);
        add_read(16'h7FFF);
        add_read(16'h67FF);
        add_read(16'h0010);
        add_read(16'h1FFF);
        // Reads issued while response credits are held back
        build_phase = GRANT_HOLD;
        foreach (bp_addr[i])
            add_read(bp_addr[i]);
        repeat (64)
            add_random_row();
    endtask

    ////////////////////
    // Per-cycle work
    ////////////////////

    task automatic collect_response();
        cpu_data_t exp;
        cpu_addr_t addr;
        if (o_rsp_valid) begin
            rsp_owed--;
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("Response at %0t ns arrived with no read outstanding", $time);
            end else begin
                exp = exp_q.pop_front();
                addr = exp_addr_q.pop_front();
                assert (o_rsp_data === exp) else begin
                    data_errs++;
                    $display("error at %0t ns: read of %h returned %h, expected %h",
                             $time, addr, o_rsp_data, exp);
                end
            end
        end
    endtask

    task automatic grant_credit();
        logic grant;
        grant = 1'b0;
        // Never grant more than the reads still owed
        if (rsp_owed < exp_q.size()) begin
            case (grant_mode)
                GRANT_EAGER:  grant = 1'b1;
                GRANT_SLOW:   grant = (rsp_owed == 0);
                GRANT_RANDOM: grant = (($random(seed) & 1) != 0);
                default:      grant = 1'b0;
            endcase
        end
        if (grant)
            rsp_owed++;
        i_rsp_credit <= grant;
    endtask

    task automatic issue_request();
        row_t row;
        i_req_valid <= 1'b0;
        if (o_req_credit)
            req_credits++;
        assert (req_credits >= 0 && req_credits <= `CPU_BUS_REQ_DEPTH) else begin
            proto_errs++;
            $display("Request credit count out of range at %0t ns", $time);
        end
        if (row_idx >= tbl.size())
            return;
        row = tbl[row_idx];
        if (row.phase != cur_phase) begin
            // Drain before the credit pattern changes
            if (exp_q.size() != 0)
                return;
            cur_phase = row.phase;
            grant_mode = int'(row.phase);
        end
        if (req_credits == 0) begin
            if (grant_mode == GRANT_HOLD) begin
                stall_cnt++;
                // Issue has stopped, now let responses out one by one
                if (stall_cnt == STALL_CYCLES) begin
                    stall_seen = 1'b1;
                    grant_mode = GRANT_SLOW;
                end
            end
            return;
        end
        req_credits--;
        row_idx++;
        i_req_valid <= 1'b1;
        i_req_rw <= row.rw;
        i_req_addr <= row.addr;
        i_req_wdata <= row.data;
        apply_model(row);
    endtask

    task automatic run_cycle();
        @(posedge i_clk);
        collect_response();
        grant_credit();
        issue_request();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        i_arst_n = 1'b0;
        i_req_valid = 1'b0;
        i_req_rw = 1'b0;
        i_req_addr = '0;
        i_req_wdata = '0;
        i_rsp_credit = 1'b0;
        build_table();
        cycle_limit = 40 * tbl.size() + 200;
        repeat (4) @(posedge i_clk);
        i_arst_n <= 1'b1;
        while (row_idx < tbl.size() || exp_q.size() != 0)
            run_cycle();
        // Let the last request credits come home
        repeat (4)
            run_cycle();
        assert (stall_seen) else begin
            proto_errs++;
            $display("Issue never stalled while response credits were held back");
        end
        assert (req_credits == `CPU_BUS_REQ_DEPTH) else begin
            proto_errs++;
            $display("Not every request credit was returned");
        end
        $display("Errors: %0d data, %0d protocol, %0d assertion",
                 data_errs, proto_errs, dut.chk.fail_count);
        if (data_errs == 0 && proto_errs == 0 && dut.chk.fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Test timed out after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
cpu_bus_pkg.sv
cpu_bus_if.sv
cpu_bus_dispatch.sv
cpu_bus_bank.sv
cpu_bus_collect.sv
cpu_bus_map.sv
cpu_bus_checker.sv
cpu_bus_tb.sv

// File: Bender.yml
package:
  name: cpu_bus_map

export_include_dirs:
  - .

sources:
  - files:
      - cpu_bus_pkg.sv
      - cpu_bus_if.sv
      - cpu_bus_dispatch.sv
      - cpu_bus_bank.sv
      - cpu_bus_collect.sv
      - cpu_bus_map.sv
  - target: test
    files:
      - cpu_bus_checker.sv
      - cpu_bus_tb.sv
